//--- hdl/mmc3_cfg.svh
// ---------------------------------------------------------------------
// MMC3 mapper constants: widths, address windows, fixed banks, A12 filter
// ---------------------------------------------------------------------
`ifndef MMC3_CFG_SVH
`define MMC3_CFG_SVH

// Bus widths
`define MMC3_ADDR_W          22       // Output memory address
`define MMC3_CPU_ADDR_W      16       // CPU address bus
`define MMC3_DATA_W          8        // CPU data bus
`define MMC3_CHR_ADDR_W      14       // PPU address bus

// Bank numbers
`define MMC3_PRG_BANK_W      6        // 8 KB PRG bank number
`define MMC3_CHR_BANK_W      8        // 1 KB CHR bank number
`define MMC3_CHR_BANKS       6        // R0..R5
`define MMC3_PRG_LAST        6'h3F    // Fixed at $E000
`define MMC3_PRG_SECOND_LAST 6'h3E    // At $C000 or $8000 by PRG mode

// Output space tags, placed above the in-bank offset
`define MMC3_PRG_RAM_BASE    9'b111100000  // 8 KB RAM window, upper 9 bits
`define MMC3_CHR_ROM_TAG     4'b1000       // CHR ROM region, upper 4 bits

// Scanline detection
`define MMC3_A12_FILTER      16       // Low ce cycles before a rise counts
`define MMC3_IRQ_CNT_W       8        // Scanline counter and latch

`endif

//--- hdl/mmc3_pkg.sv
// ---------------------------------------------------------------------
// MMC3 mapper types: bus structs, bank state, IRQ control, data views
// ---------------------------------------------------------------------
`include "mmc3_cfg.svh"

package mmc3_pkg;

	typedef struct packed {
		logic [`MMC3_CPU_ADDR_W-1:0] addr;   // CPU address
		logic [`MMC3_DATA_W-1:0]     data;   // Write data
		logic                        write;  // Write cycle
		logic                        read;   // Read cycle
	} cpu_bus_t;

	typedef struct packed {
		logic chr_is_ram;    // CHR writes allowed
		logic mirror_init;   // Mirroring after reset, 1 = horizontal
	} cart_cfg_t;

	typedef struct packed {
		logic [`MMC3_PRG_BANK_W-1:0] prg_bank0;  // R6
		logic [`MMC3_PRG_BANK_W-1:0] prg_bank1;  // R7
		logic [`MMC3_CHR_BANKS-1:0][`MMC3_CHR_BANK_W-1:0] chr_bank;  // R0..R5, R0/R1 in 2 KB units
		logic prg_mode;      // Swaps $8000 and $C000
		logic chr_invert;    // Swaps CHR halves
		logic mirror_h;      // 1 = horizontal
		logic ram_enable;    // PRG RAM chip enable
		logic ram_protect;   // PRG RAM write protect
	} bank_state_t;

	typedef struct packed {
		logic [`MMC3_IRQ_CNT_W-1:0] latch;  // Reload value
		logic reload;        // Pulse, $C001
		logic enable_set;    // Pulse, $E001
		logic disable_ack;   // Pulse, $E000
	} irq_ctrl_t;

	// Bank select byte at $8000
	typedef struct packed {
		logic       chr_invert;  // D7
		logic       prg_mode;    // D6
		logic [2:0] rsvd;
		logic [2:0] target;      // Register loaded by $8001
	} bank_sel_t;

	// RAM control byte at $A001
	typedef struct packed {
		logic       enable;      // D7
		logic       protect;     // D6
		logic [5:0] rsvd;
	} ram_ctl_t;

	typedef union packed {
		bank_sel_t sel;
		ram_ctl_t  ram;
	} cpu_data_u;

	typedef struct packed {
		logic [`MMC3_ADDR_W-1:0] addr;  // PRG ROM or RAM address
		logic                    allow; // Access permitted
	} prg_map_t;

	typedef struct packed {
		logic [`MMC3_ADDR_W-1:0] addr;  // CHR address
		logic allow;         // CHR write permitted
		logic vram_a10;      // Nametable A10
		logic vram_ce;       // Route to internal VRAM
	} chr_map_t;

endpackage

//--- hdl/mmc3_regs.sv
// ---------------------------------------------------------------------
// MMC3 register file: decodes CPU writes at $8000-$FFFF into bank,
// mode, mirroring and RAM state, and issues IRQ command pulses
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module mmc3_regs (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  ce,           // CPU cycle enable
	input  mmc3_pkg::cpu_bus_t    cpu,
	input  logic                  mirror_init,  // Cartridge mirroring at reset
	output mmc3_pkg::bank_state_t banks,
	output mmc3_pkg::irq_ctrl_t   irq_ctl
);

	mmc3_pkg::cpu_data_u data;   // Data byte, two views
	logic [2:0]          target; // Bank register picked by $8000
	logic                wr_en;  // Accepted write to mapper space

	assign data  = cpu.data;
	assign wr_en = ce && cpu.write && cpu.addr[15];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			target            <= '0;
			banks.prg_bank0   <= '0;
			banks.prg_bank1   <= '0;
			banks.chr_bank    <= '0;
			banks.prg_mode    <= 1'b0;
			banks.chr_invert  <= 1'b0;
			banks.mirror_h    <= mirror_init;  // Hard-wired default
			banks.ram_enable  <= 1'b0;
			banks.ram_protect <= 1'b0;
			irq_ctl           <= '0;
		end else begin
			// Command pulses live for one clk only
			irq_ctl.reload      <= 1'b0;
			irq_ctl.enable_set  <= 1'b0;
			irq_ctl.disable_ack <= 1'b0;
			if (wr_en) begin
				// A14, A13 pick the register pair, A0 the even/odd half
				case ({cpu.addr[14:13], cpu.addr[0]})
					3'b00_0: begin                       // $8000 bank select
						target           <= data.sel.target;
						banks.prg_mode   <= data.sel.prg_mode;
						banks.chr_invert <= data.sel.chr_invert;
					end
					3'b00_1: begin                       // $8001 bank data
						case (target)
							3'd0, 3'd1: banks.chr_bank[target] <= {1'b0, cpu.data[7:1]}; // 2 KB
							3'd2, 3'd3,
							3'd4, 3'd5: banks.chr_bank[target] <= cpu.data;  // 1 KB
							3'd6: banks.prg_bank0 <= cpu.data[`MMC3_PRG_BANK_W-1:0];
							3'd7: banks.prg_bank1 <= cpu.data[`MMC3_PRG_BANK_W-1:0];
							default: ;
						endcase
					end
					3'b01_0: banks.mirror_h <= cpu.data[0];  // $A000
					3'b01_1: begin                       // $A001 RAM control
						banks.ram_enable  <= data.ram.enable;
						banks.ram_protect <= data.ram.protect;
					end
					3'b10_0: irq_ctl.latch       <= cpu.data;  // $C000
					3'b10_1: irq_ctl.reload      <= 1'b1;      // $C001
					3'b11_0: irq_ctl.disable_ack <= 1'b1;      // $E000, also acks
					3'b11_1: irq_ctl.enable_set  <= 1'b1;      // $E001
					default: ;
				endcase
			end
		end
	end

	// The IRQ unit resolves one command per cycle
	a_one_irq_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({irq_ctl.reload, irq_ctl.enable_set, irq_ctl.disable_ack}))
		else $error("mmc3_regs: more than one IRQ command pulse");

endmodule

//--- hdl/mmc3_prg_map.sv
// ---------------------------------------------------------------------
// MMC3 PRG mapping: 8 KB ROM banks at $8000-$FFFF, RAM at $6000-$7FFF
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module mmc3_prg_map (
	input  mmc3_pkg::cpu_bus_t    cpu,
	input  mmc3_pkg::bank_state_t banks,
	output mmc3_pkg::prg_map_t    prg
);

	logic [`MMC3_PRG_BANK_W-1:0] prg_sel;   // 8 KB bank for this window
	logic [`MMC3_ADDR_W-1:0]     rom_addr;
	logic [`MMC3_ADDR_W-1:0]     ram_addr;
	logic                        ram_win;   // $6000-$7FFF
	logic                        ram_hit;   // Permitted RAM access

	always_comb begin
		case ({cpu.addr[14:13], banks.prg_mode})
			3'b00_0: prg_sel = banks.prg_bank0;          // $8000 R6
			3'b00_1: prg_sel = `MMC3_PRG_SECOND_LAST;    // $8000 fixed
			3'b01_0,
			3'b01_1: prg_sel = banks.prg_bank1;          // $A000 R7 either mode
			3'b10_0: prg_sel = `MMC3_PRG_SECOND_LAST;    // $C000 fixed
			3'b10_1: prg_sel = banks.prg_bank0;          // $C000 R6
			default: prg_sel = `MMC3_PRG_LAST;           // $E000 always last
		endcase

		rom_addr = {{(`MMC3_ADDR_W-`MMC3_PRG_BANK_W-13){1'b0}}, prg_sel, cpu.addr[12:0]};
		ram_addr = {`MMC3_PRG_RAM_BASE, cpu.addr[12:0]};

		ram_win = (cpu.addr[15:13] == 3'b011);
		ram_hit = ram_win && banks.ram_enable
		          && (cpu.read || (cpu.write && !banks.ram_protect)); // Protect blocks writes only

		prg.addr  = ram_win ? ram_addr : rom_addr;
		prg.allow = (cpu.addr[15] && cpu.read) || ram_hit;  // ROM is read only

		// Nothing below the RAM window belongs to the cartridge
		a_no_low_allow: assert (!(prg.allow && (cpu.addr < 16'h6000)))
			else $error("mmc3_prg_map: allow below $6000");
	end

endmodule

//--- hdl/mmc3_chr_map.sv
// ---------------------------------------------------------------------
// MMC3 CHR mapping: 2 KB and 1 KB banks with A12 inversion, mirroring
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module mmc3_chr_map (
	input  logic [`MMC3_CHR_ADDR_W-1:0] chr_addr,
	input  mmc3_pkg::bank_state_t       banks,
	input  logic                        chr_is_ram,  // Cartridge has CHR RAM
	output mmc3_pkg::chr_map_t          chr
);

	logic                        half;     // A12 after inversion
	logic [`MMC3_CHR_BANK_W-1:0] chr_sel;  // 1 KB bank for this address

	assign half = chr_addr[12] ^ banks.chr_invert;

	always_comb begin
		case ({half, chr_addr[11:10]})
			3'b0_00,
			3'b0_01: chr_sel = {banks.chr_bank[0][6:0], chr_addr[10]}; // R0, 2 KB
			3'b0_10,
			3'b0_11: chr_sel = {banks.chr_bank[1][6:0], chr_addr[10]}; // R1, 2 KB
			3'b1_00: chr_sel = banks.chr_bank[2];
			3'b1_01: chr_sel = banks.chr_bank[3];
			3'b1_10: chr_sel = banks.chr_bank[4];
			default: chr_sel = banks.chr_bank[5];
		endcase
	end

	assign chr.addr     = {`MMC3_CHR_ROM_TAG, chr_sel, chr_addr[9:0]};
	assign chr.allow    = chr_is_ram;
	assign chr.vram_a10 = banks.mirror_h ? chr_addr[11] : chr_addr[10]; // Horiz uses A11
	assign chr.vram_ce  = chr_addr[13];   // Nametables live in CIRAM

endmodule

//--- hdl/mmc3_scanline_irq.sv
// ---------------------------------------------------------------------
// MMC3 scanline IRQ: filters PPU A12 rises, counts them down from the
// latch and raises the IRQ on reaching zero
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module mmc3_scanline_irq (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ce,       // CPU cycle enable
	input  logic                chr_a12,  // PPU A12
	input  mmc3_pkg::irq_ctrl_t irq_ctl,
	output logic                irq
);

	localparam int FILT_W = $clog2(`MMC3_A12_FILTER);

	logic [FILT_W-1:0]          filt_cnt;     // Low cycles still required
	logic [`MMC3_IRQ_CNT_W-1:0] counter;      // Scanline counter
	logic [`MMC3_IRQ_CNT_W-1:0] counter_nxt;
	logic                       reload_pend;  // Set by $C001
	logic                       irq_en;
	logic                       a12_edge;     // Filtered rising edge

	// A12 must sit low long enough, so sprite fetches don't double count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			filt_cnt <= '0;
		end else if (ce) begin
			if (chr_a12)
				filt_cnt <= FILT_W'(`MMC3_A12_FILTER - 1);  // Restart cool-down
			else if (filt_cnt != '0)
				filt_cnt <= filt_cnt - 1'b1;
		end
	end

	assign a12_edge    = ce && chr_a12 && (filt_cnt == '0);
	assign counter_nxt = ((counter == '0) || reload_pend) ? irq_ctl.latch
	                                                      : counter - 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			counter     <= '0;
			reload_pend <= 1'b0;
			irq_en      <= 1'b0;
			irq         <= 1'b0;
		end else begin
			if (a12_edge) begin
				counter     <= counter_nxt;
				reload_pend <= 1'b0;
				// New behavior, fires on every zero
				if ((counter_nxt == '0) && irq_en)
					irq <= 1'b1;
			end
			if (irq_ctl.reload)
				reload_pend <= 1'b1;  // Wins over a same-cycle clear
			if (irq_ctl.enable_set)
				irq_en <= 1'b1;
			if (irq_ctl.disable_ack) begin
				irq_en <= 1'b0;
				irq    <= 1'b0;       // Disable also acknowledges
			end
		end
	end

	// A pending IRQ can only come from an enabled counter
	a_irq_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(irq) |-> $past(irq_en))
		else $error("mmc3_scanline_irq: irq rose while disabled");

endmodule

//--- hdl/mmc3_mapper.sv
// ---------------------------------------------------------------------
// MMC3 mapper top: register file, PRG and CHR mapping, scanline IRQ
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module mmc3_mapper (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        ce,        // CPU cycle enable
	input  mmc3_pkg::cpu_bus_t          cpu,
	input  logic [`MMC3_CHR_ADDR_W-1:0] chr_addr,  // PPU address
	input  mmc3_pkg::cart_cfg_t         cfg,
	output mmc3_pkg::prg_map_t          prg,
	output mmc3_pkg::chr_map_t          chr,
	output logic                        irq
);

	mmc3_pkg::bank_state_t banks;    // Registered bank and mode state
	mmc3_pkg::irq_ctrl_t   irq_ctl;  // Latch and command pulses

	mmc3_regs i_mmc3_regs (
		.clk         (clk),
		.rst_n       (rst_n),
		.ce          (ce),
		.cpu         (cpu),
		.mirror_init (cfg.mirror_init),
		.banks       (banks),
		.irq_ctl     (irq_ctl)
	);

	mmc3_prg_map i_mmc3_prg_map (
		.cpu   (cpu),
		.banks (banks),
		.prg   (prg)
	);

	mmc3_chr_map i_mmc3_chr_map (
		.chr_addr   (chr_addr),
		.banks      (banks),
		.chr_is_ram (cfg.chr_is_ram),
		.chr        (chr)
	);

	mmc3_scanline_irq i_mmc3_scanline_irq (
		.clk     (clk),
		.rst_n   (rst_n),
		.ce      (ce),
		.chr_a12 (chr_addr[12]),   // Pattern table half toggles per scanline
		.irq_ctl (irq_ctl),
		.irq     (irq)
	);

endmodule

//--- testbench/tb_mmc3_mapper.sv
// ---------------------------------------------------------------------
// MMC3 mapper testbench: PRG/CHR banking, PRG RAM, mirroring, IRQ
// ---------------------------------------------------------------------
`timescale 1ns/10ps
`include "mmc3_cfg.svh"

module tb_mmc3_mapper;

	localparam int PULSE_CYCLES   = 4 * 18;  // One high ce cycle plus a long low gap
	localparam int PULSE_COUNT    = 14;      // Two counting rounds, latch up to 5
	localparam int WRITE_CYCLES   = 12;
	localparam int WRITE_COUNT    = 40;
	localparam int TEST_CYCLES    = PULSE_COUNT * PULSE_CYCLES
	                                + WRITE_COUNT * WRITE_CYCLES + 400;
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 1000;

	logic                clk      = 1'b0;
	logic                ce       = 1'b0;
	logic [1:0]          ce_phase = 2'd0;  // ce every fourth cycle
	logic                rst_n;
	mmc3_pkg::cpu_bus_t  cpu;
	logic [13:0]         chr_addr;
	mmc3_pkg::cart_cfg_t cfg;
	mmc3_pkg::prg_map_t  prg;
	mmc3_pkg::chr_map_t  chr;
	logic                irq;

	int         n_checks;
	int         n_errors;
	logic [7:0] chr_data [6];  // Bytes last written to R0..R5

	mmc3_mapper i_mmc3_mapper (
		.clk      (clk),
		.rst_n    (rst_n),
		.ce       (ce),
		.cpu      (cpu),
		.chr_addr (chr_addr),
		.cfg      (cfg),
		.prg      (prg),
		.chr      (chr),
		.irq      (irq)
	);

	always #2 clk = ~clk;

	always @(negedge clk) begin
		ce_phase <= ce_phase + 2'd1;
		ce       <= (ce_phase == 2'd3);
	end

	task automatic check(input string name, input logic [31:0] expected,
	                     input logic [31:0] actual);
		n_checks++;
		if (expected !== actual) begin
			n_errors++;
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Returns on the posedge that completes n ce cycles
	task automatic wait_ce(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(posedge clk);
			if (ce)
				seen++;
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge clk);
		cpu.addr  = addr;
		cpu.data  = data;
		cpu.write = 1'b1;
		cpu.read  = 1'b0;
		wait_ce(1);              // Accepted here
		@(negedge clk);
		cpu.write = 1'b0;
	endtask

	// Mapping is combinational, sampled mid low phase
	task automatic drive_bus(input logic [15:0] addr, input logic rd, input logic wr);
		@(negedge clk);
		cpu.addr  = addr;
		cpu.read  = rd;
		cpu.write = wr;
		#1;
	endtask

	task automatic drive_chr(input logic [13:0] addr);
		@(negedge clk);
		chr_addr = addr;
		#1;
	endtask

	// A12 high for one ce cycle, then low for gap ce cycles
	task automatic a12_pulse(input int gap);
		@(negedge clk);
		chr_addr = 14'h1000;
		wait_ce(1);
		@(negedge clk);
		chr_addr = 14'h0000;
		wait_ce(gap);
		@(negedge clk);
		#1;
	endtask

	function automatic logic [5:0] prg_bank(input logic [1:0] win, input logic mode,
	                                        input logic [5:0] b6, input logic [5:0] b7);
		logic [5:0] bank;
		case (win)
			2'd0:    bank = mode ? `MMC3_PRG_SECOND_LAST : b6;  // $8000
			2'd1:    bank = b7;                               // $A000
			2'd2:    bank = mode ? b6 : `MMC3_PRG_SECOND_LAST;  // $C000
			default: bank = `MMC3_PRG_LAST;
		endcase
		return bank;
	endfunction

	function automatic logic [31:0] rom_addr(input logic [5:0] bank, input logic [15:0] a);
		return {13'b0, bank, a[12:0]};
	endfunction

	function automatic logic [31:0] ram_addr(input logic [15:0] a);
		return {10'b0, `MMC3_PRG_RAM_BASE, a[12:0]};
	endfunction

	// 2 KB half takes R0/R1 without bit 0 plus A10, 1 KB half takes R2..R5
	function automatic logic [31:0] chr_rom_addr(input logic [13:0] a, input logic inv);
		logic [7:0] bank;
		int         idx;
		idx = 2 + int'(a[11:10]);
		if ((a[12] ^ inv) == 1'b0)
			bank = {chr_data[int'(a[11])][7:1], a[10]};
		else
			bank = chr_data[idx];
		return {10'b0, `MMC3_CHR_ROM_TAG, bank, a[9:0]};
	endfunction

	task automatic check_ram(input string state, input logic wr, input logic exp_allow);
		logic [15:0] a;
		a = {3'b011, 13'($urandom)};
		drive_bus(a, !wr, wr);
		check($sformatf("test_prg_ram %s %s allow", state, wr ? "write" : "read"),
		      32'(exp_allow), 32'(prg.allow));
		if (exp_allow)
			check($sformatf("test_prg_ram %s addr", state), ram_addr(a), 32'(prg.addr));
	endtask

	task automatic test_reset_defaults();
		check("test_reset_defaults irq", 32'd0, 32'(irq));
		drive_bus(16'hE123, 1'b1, 1'b0);
		check("test_reset_defaults $E000", rom_addr(`MMC3_PRG_LAST, 16'hE123), 32'(prg.addr));
		drive_bus(16'hC456, 1'b1, 1'b0);
		check("test_reset_defaults $C000", rom_addr(`MMC3_PRG_SECOND_LAST, 16'hC456),
		      32'(prg.addr));
		drive_bus(16'h6000, 1'b1, 1'b0);
		check("test_reset_defaults RAM allow", 32'd0, 32'(prg.allow));
		drive_chr(14'h2400);     // A10 set, A11 clear
		check("test_reset_defaults vram_a10 $2400",
		      32'(cfg.mirror_init ? 1'b0 : 1'b1), 32'(chr.vram_a10));
		drive_chr(14'h2800);
		check("test_reset_defaults vram_a10 $2800",
		      32'(cfg.mirror_init ? 1'b1 : 1'b0), 32'(chr.vram_a10));
	endtask

	task automatic test_prg_banking();
		logic [7:0]  d6;
		logic [7:0]  d7;
		logic [15:0] a;
		int          mode;
		int          w;
		d6 = 8'($urandom);
		d7 = 8'($urandom);
		cpu_write(16'h8000, 8'h06);
		cpu_write(16'h8001, d6);
		cpu_write(16'h8000, 8'h07);
		cpu_write(16'h8001, d7);
		for (mode = 0; mode < 2; mode++) begin
			cpu_write(16'h8000, mode ? 8'h40 : 8'h00);  // D6 is the PRG mode
			for (w = 0; w < 4; w++) begin
				a = {1'b1, 2'(w), 13'($urandom)};
				drive_bus(a, 1'b1, 1'b0);
				check($sformatf("test_prg_banking mode %0d addr %h", mode, a),
				      rom_addr(prg_bank(2'(w), 1'(mode), d6[5:0], d7[5:0]), a),
				      32'(prg.addr));
				check($sformatf("test_prg_banking mode %0d allow", mode), 32'd1,
				      32'(prg.allow));
			end
		end
	endtask

	task automatic test_chr_banking();
		logic [13:0] a;
		int          i;
		int          inv;
		for (i = 0; i < 6; i++) begin
			chr_data[i] = 8'($urandom);
			cpu_write(16'h8000, 8'(i));
			cpu_write(16'h8001, chr_data[i]);
		end
		for (inv = 0; inv < 2; inv++) begin
			cpu_write(16'h8000, inv ? 8'h80 : 8'h00);  // D7 swaps the halves
			for (i = 0; i < 8; i++) begin
				a = {1'b0, 3'(i), 10'($urandom)};        // Every 1 KB slot
				drive_chr(a);
				check($sformatf("test_chr_banking inv %0d addr %h", inv, a),
				      chr_rom_addr(a, 1'(inv)), 32'(chr.addr));
			end
		end
		check("test_chr_banking allow rom", 32'd0, 32'(chr.allow));
		@(negedge clk);
		cfg.chr_is_ram = 1'b1;
		#1;
		check("test_chr_banking allow ram", 32'd1, 32'(chr.allow));
		@(negedge clk);
		cfg.chr_is_ram = 1'b0;
	endtask

	task automatic test_prg_ram();
		cpu_write(16'hA001, 8'h00);
		check_ram("disabled", 1'b0, 1'b0);
		check_ram("disabled", 1'b1, 1'b0);
		cpu_write(16'hA001, 8'h80);
		check_ram("enabled", 1'b0, 1'b1);
		check_ram("enabled", 1'b1, 1'b1);
		cpu_write(16'hA001, 8'hC0);  // Enable plus protect
		check_ram("protected", 1'b0, 1'b1);
		check_ram("protected", 1'b1, 1'b0);
		drive_bus(16'h0000, 1'b0, 1'b0);
	endtask

	task automatic test_mirroring();
		logic [13:0] a;
		int          m;
		int          i;
		for (m = 0; m < 2; m++) begin
			cpu_write(16'hA000, 8'(m));
			for (i = 0; i < 4; i++) begin
				a = {2'b10, 2'(i), 10'($urandom)};  // $2000-$2FFF nametables
				drive_chr(a);
				check($sformatf("test_mirroring mode %0d addr %h", m, a),
				      32'(m ? a[11] : a[10]), 32'(chr.vram_a10));
				check("test_mirroring vram_ce", 32'd1, 32'(chr.vram_ce));
			end
		end
		drive_chr(14'h0000);
		check("test_mirroring vram_ce pattern", 32'd0, 32'(chr.vram_ce));
	endtask

	task automatic test_scanline_irq();
		int n;
		int k;
		n = 2 + int'($urandom % 32'd4);
		drive_chr(14'h0000);
		wait_ce(`MMC3_A12_FILTER);   // Filter settled
		cpu_write(16'hC000, 8'(n));
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		for (k = 1; k <= n + 1; k++) begin
			if (k == 1) begin
				a12_pulse(4);                 // Short gap after it
				a12_pulse(`MMC3_A12_FILTER);  // Filtered out
			end else begin
				a12_pulse(`MMC3_A12_FILTER);
			end
			check($sformatf("test_scanline_irq latch %0d pulse %0d", n, k),
			      32'(k == n + 1), 32'(irq));
		end
		cpu_write(16'hE000, 8'h00);
		@(negedge clk);              // Ack pulse lands one edge later
		#1;
		check("test_scanline_irq ack", 32'd0, 32'(irq));
		// Disabled now, count down to zero once more
		cpu_write(16'hC001, 8'h00);
		for (k = 1; k <= n + 1; k++) begin
			a12_pulse(`MMC3_A12_FILTER);
			check($sformatf("test_scanline_irq disabled pulse %0d", k), 32'd0, 32'(irq));
		end
	endtask

	initial begin
		logic [31:0] seed_word;
		seed_word       = $urandom(32'hfbdcd5f5);
		n_checks        = 0;
		n_errors        = 0;
		rst_n           = 1'b0;
		cpu             = '0;
		chr_addr        = '0;
		cfg.chr_is_ram  = 1'b0;
		cfg.mirror_init = 1'b1;      // Horizontal at reset
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		test_reset_defaults();
		test_prg_banking();
		test_chr_banking();
		test_prg_ram();
		test_mirroring();
		test_scanline_irq();
		$display("Checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("Timeout: tests still running after %0d clock cycles", TIMEOUT_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- mmc3_mapper.f
+incdir+hdl
hdl/mmc3_pkg.sv
hdl/mmc3_regs.sv
hdl/mmc3_prg_map.sv
hdl/mmc3_chr_map.sv
hdl/mmc3_scanline_irq.sv
hdl/mmc3_mapper.sv
testbench/tb_mmc3_mapper.sv

//--- Makefile
TOP = tb_mmc3_mapper

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/10ps --top-module $(TOP) -f mmc3_mapper.f
	./obj_dir/V$(TOP) | awk '{ print } /^Result: PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
